// ==== compile.f ====
+incdir+logic
logic/dcore_pkg.sv
logic/adc_retimer.sv
logic/adc_unfolding.sv
logic/mm_cdr.sv
logic/pi_ctl_scaler.sv
logic/snapshot_buffer.sv
logic/digital_core.sv
testbench/tb_clock_gen.sv
testbench/tb_digital_core.sv

// ==== logic/adc_retimer.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "dcore_cfg.svh"

module adc_retimer (
    input wire logic clk_adc,
    input wire logic reset_i,
    input wire dcore_pkg::adc_mag_t [`DCORE_NTI-1:0] adc_mag_i,
    input wire logic [`DCORE_NTI-1:0] adc_sign_i,
    output dcore_pkg::adc_mag_t [`DCORE_NTI-1:0] ret_mag_o,
    output logic [`DCORE_NTI-1:0] ret_sign_o
);

    // All slices sampled on the same edge to form one frame
    always_ff @(posedge clk_adc) begin
        if (reset_i) begin
            ret_mag_o  <= '0;
            ret_sign_o <= '0;
        end else begin
            ret_mag_o  <= adc_mag_i;
            ret_sign_o <= adc_sign_i;
        end
    end

endmodule

`default_nettype wire

// ==== logic/adc_unfolding.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "dcore_cfg.svh"

module adc_unfolding (
    input wire logic clk_adc,
    input wire logic reset_i,
    input wire dcore_pkg::adc_mag_t [`DCORE_NTI-1:0] ret_mag_i,
    input wire logic [`DCORE_NTI-1:0] ret_sign_i,
    input wire logic en_pfd_cal_i,
    input wire logic en_ext_offset_i,
    input wire dcore_pkg::sample_t [`DCORE_NTI-1:0] ext_offset_i,
    output dcore_pkg::frame_t frame_o
);

    import dcore_pkg::*;

    localparam int SW = `DCORE_NADC + 1;
    localparam int ACC_W = SW + `DCORE_NAVG_LOG;
    localparam int AVG_LEN = 2 ** `DCORE_NAVG_LOG;
    localparam logic signed [SW:0] SAT_MAX = 2 ** (SW - 1) - 1;
    localparam logic signed [SW:0] SAT_MIN = -(2 ** (SW - 1));

    logic [`DCORE_NAVG_LOG:0] win_cnt;
    logic win_end;
    sample_t raw [`DCORE_NTI];
    sample_t offset [`DCORE_NTI];
    sample_t cal_offset [`DCORE_NTI];
    sample_t sat [`DCORE_NTI];
    logic signed [SW:0] diff [`DCORE_NTI];
    logic signed [ACC_W-1:0] acc [`DCORE_NTI];
    logic signed [ACC_W-1:0] acc_next [`DCORE_NTI];

    assign win_end = (win_cnt == AVG_LEN - 1);

    always_comb begin
        for (int k = 0; k < `DCORE_NTI; k++) begin
            // Sign bit set means positive
            if (ret_sign_i[k]) begin
                raw[k] = sample_t'({1'b0, ret_mag_i[k]});
            end else begin
                raw[k] = -sample_t'({1'b0, ret_mag_i[k]});
            end

            offset[k] = en_ext_offset_i ? sample_t'(ext_offset_i[k]) : cal_offset[k];
            diff[k] = raw[k] - offset[k];

            if (diff[k] > SAT_MAX) begin
                sat[k] = sample_t'(SAT_MAX);
            end else if (diff[k] < SAT_MIN) begin
                sat[k] = sample_t'(SAT_MIN);
            end else begin
                sat[k] = diff[k][SW-1:0];
            end

            acc_next[k] = acc[k] + raw[k];
        end
    end

    always_ff @(posedge clk_adc) begin
        for (int k = 0; k < `DCORE_NTI; k++) begin
            frame_o[k*SW +: SW] <= sat[k];
        end
    end

    // Averaging over the window, offset held while disabled
    always_ff @(posedge clk_adc) begin
        if (reset_i) begin
            win_cnt <= '0;
            for (int k = 0; k < `DCORE_NTI; k++) begin
                acc[k]        <= '0;
                cal_offset[k] <= '0;
            end
        end else if (en_pfd_cal_i) begin
            win_cnt <= win_end ? '0 : win_cnt + 1'b1;
            for (int k = 0; k < `DCORE_NTI; k++) begin
                if (win_end) begin
                    acc[k]        <= '0;
                    cal_offset[k] <= sample_t'(acc_next[k] >>> `DCORE_NAVG_LOG);
                end else begin
                    acc[k] <= acc_next[k];
                end
            end
        end else begin
            win_cnt <= '0;
            for (int k = 0; k < `DCORE_NTI; k++) begin
                acc[k] <= '0;
            end
        end
    end

    a_win_bound: assert property (
        @(posedge clk_adc) disable iff (reset_i)
        win_cnt < AVG_LEN
    );

endmodule

`default_nettype wire

// ==== logic/dcore_cfg.svh ====
`ifndef DCORE_CFG_SVH
`define DCORE_CFG_SVH

// Interleaved ADC slices
`define DCORE_NTI 4

// Magnitude bits per slice, sign comes separately
`define DCORE_NADC 7

// Phase interpolator code width
`define DCORE_NPI 9

// Interpolator outputs
`define DCORE_NOUT 4

// Offset calibration window, log2 of frames
`define DCORE_NAVG_LOG 4

// Snapshot memory depth in frames
`define DCORE_DEPTH 32

// Drain link credits after reset
`define DCORE_CREDITS 4

`endif

// ==== logic/dcore_pkg.sv ====
`include "dcore_cfg.svh"

package dcore_pkg;

    // Slice magnitude as delivered by the comparators
    typedef logic [`DCORE_NADC-1:0] adc_mag_t;

    // One extra bit holds the sign after unfolding
    typedef logic signed [`DCORE_NADC:0] sample_t;

    // Slice 0 in the lowest bits
    typedef logic [`DCORE_NTI*(`DCORE_NADC+1)-1:0] frame_t;

    typedef logic [`DCORE_NPI-1:0] pi_code_t;

    typedef enum logic [1:0] {
        SNAP_IDLE,
        SNAP_CAPTURE,
        SNAP_DRAIN
    } snap_state_t;

endpackage

// ==== logic/digital_core.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "dcore_cfg.svh"

module digital_core (
    input wire logic clk_adc,
    input wire logic reset_i,
    input wire dcore_pkg::adc_mag_t [`DCORE_NTI-1:0] adc_mag_i,
    input wire logic [`DCORE_NTI-1:0] adc_sign_i,
    input wire logic en_pfd_cal_i,
    input wire logic en_ext_offset_i,
    input wire dcore_pkg::sample_t [`DCORE_NTI-1:0] ext_offset_i,
    input wire dcore_pkg::pi_code_t [`DCORE_NOUT-1:0] pi_offset_i,
    input wire dcore_pkg::pi_code_t [`DCORE_NOUT-1:0] pi_scale_i,
    input wire logic dump_start_i,
    input wire logic snap_credit_i,
    output dcore_pkg::pi_code_t [`DCORE_NOUT-1:0] pi_ctl_o,
    output logic snap_valid_o,
    output dcore_pkg::frame_t snap_data_o,
    output logic snap_busy_o
);

    import dcore_pkg::*;

    adc_mag_t [`DCORE_NTI-1:0] ret_mag;
    logic [`DCORE_NTI-1:0] ret_sign;
    frame_t frame;
    pi_code_t pi_code;

    adc_retimer retimer_i (
        .clk_adc    (clk_adc),
        .reset_i    (reset_i),
        .adc_mag_i  (adc_mag_i),
        .adc_sign_i (adc_sign_i),
        .ret_mag_o  (ret_mag),
        .ret_sign_o (ret_sign)
    );

    // Offset removal and calibration for all slices
    adc_unfolding unfolding_i (
        .clk_adc         (clk_adc),
        .reset_i         (reset_i),
        .ret_mag_i       (ret_mag),
        .ret_sign_i      (ret_sign),
        .en_pfd_cal_i    (en_pfd_cal_i),
        .en_ext_offset_i (en_ext_offset_i),
        .ext_offset_i    (ext_offset_i),
        .frame_o         (frame)
    );

    mm_cdr cdr_i (
        .clk_adc  (clk_adc),
        .reset_i  (reset_i),
        .frame_i  (frame),
        .pi_ctl_o (pi_code)
    );

    pi_ctl_scaler scaler_i (
        .clk_adc     (clk_adc),
        .reset_i     (reset_i),
        .pi_ctl_i    (pi_code),
        .pi_offset_i (pi_offset_i),
        .pi_scale_i  (pi_scale_i),
        .pi_ctl_o    (pi_ctl_o)
    );

    snapshot_buffer snapshot_i (
        .clk_adc       (clk_adc),
        .reset_i       (reset_i),
        .frame_i       (frame),
        .dump_start_i  (dump_start_i),
        .snap_credit_i (snap_credit_i),
        .snap_valid_o  (snap_valid_o),
        .snap_data_o   (snap_data_o),
        .snap_busy_o   (snap_busy_o)
    );

endmodule

`default_nettype wire

// ==== logic/mm_cdr.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "dcore_cfg.svh"

module mm_cdr (
    input wire logic clk_adc,
    input wire logic reset_i,
    input wire dcore_pkg::frame_t frame_i,
    output dcore_pkg::pi_code_t pi_ctl_o
);

    import dcore_pkg::*;

    localparam int SW = `DCORE_NADC + 1;
    // Each term is bounded by two sample magnitudes, then NTI terms are summed
    localparam int ERR_W = SW + 2 + $clog2(`DCORE_NTI);

    sample_t smp [`DCORE_NTI];
    sample_t prev_last;
    logic signed [ERR_W-1:0] err_sum;

    // Value times the sign of s, zero counts as sign 0
    function automatic logic signed [ERR_W-1:0] signed_by(input sample_t v, input sample_t s);
        logic signed [ERR_W-1:0] v_ext;
        v_ext = v;
        if (s > 0) begin
            return v_ext;
        end else if (s < 0) begin
            return -v_ext;
        end else begin
            return '0;
        end
    endfunction

    always_comb begin
        for (int k = 0; k < `DCORE_NTI; k++) begin
            smp[k] = frame_i[k*SW +: SW];
        end

        // Pair across the frame boundary
        err_sum = signed_by(smp[0], prev_last) - signed_by(prev_last, smp[0]);
        for (int k = 1; k < `DCORE_NTI; k++) begin
            err_sum = err_sum + signed_by(smp[k], smp[k-1]) - signed_by(smp[k-1], smp[k]);
        end
    end

    always_ff @(posedge clk_adc) begin
        if (reset_i) begin
            prev_last <= '0;
            pi_ctl_o  <= '0;
        end else begin
            prev_last <= smp[`DCORE_NTI-1];
            // Bang-bang step, wraps naturally
            if (err_sum > 0) begin
                pi_ctl_o <= pi_ctl_o + 1'b1;
            end else if (err_sum < 0) begin
                pi_ctl_o <= pi_ctl_o - 1'b1;
            end
        end
    end

    a_code_step: assert property (
        @(posedge clk_adc) disable iff (reset_i)
        ##1 (pi_ctl_o == $past(pi_ctl_o))
            || (pi_ctl_o == pi_code_t'($past(pi_ctl_o) + 1'b1))
            || (pi_ctl_o == pi_code_t'($past(pi_ctl_o) - 1'b1))
    );

endmodule

`default_nettype wire

// ==== logic/pi_ctl_scaler.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "dcore_cfg.svh"

module pi_ctl_scaler (
    input wire logic clk_adc,
    input wire logic reset_i,
    input wire dcore_pkg::pi_code_t pi_ctl_i,
    input wire dcore_pkg::pi_code_t [`DCORE_NOUT-1:0] pi_offset_i,
    input wire dcore_pkg::pi_code_t [`DCORE_NOUT-1:0] pi_scale_i,
    output dcore_pkg::pi_code_t [`DCORE_NOUT-1:0] pi_ctl_o
);

    import dcore_pkg::*;

    localparam int NPI = `DCORE_NPI;

    pi_code_t shifted_code [`DCORE_NOUT];
    logic [2*NPI-1:0] product [`DCORE_NOUT];

    always_comb begin
        for (int j = 0; j < `DCORE_NOUT; j++) begin
            // Sum kept at code width so it wraps before scaling
            shifted_code[j] = pi_ctl_i + pi_offset_i[j];
            product[j] = shifted_code[j] * pi_scale_i[j];
        end
    end

    // Scale is a fraction of full range
    always_ff @(posedge clk_adc) begin
        if (reset_i) begin
            pi_ctl_o <= '0;
        end else begin
            for (int j = 0; j < `DCORE_NOUT; j++) begin
                pi_ctl_o[j] <= product[j][2*NPI-1:NPI];
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/snapshot_buffer.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "dcore_cfg.svh"

module snapshot_buffer (
    input wire logic clk_adc,
    input wire logic reset_i,
    input wire dcore_pkg::frame_t frame_i,
    input wire logic dump_start_i,
    input wire logic snap_credit_i,
    output logic snap_valid_o,
    output dcore_pkg::frame_t snap_data_o,
    output logic snap_busy_o
);

    import dcore_pkg::*;

    localparam int DEPTH = `DCORE_DEPTH;
    localparam int ADDR_W = $clog2(DEPTH);
    localparam int CRED_W = $clog2(`DCORE_CREDITS + 1);

    snap_state_t state;
    frame_t mem [DEPTH];
    logic [ADDR_W-1:0] addr;
    logic [CRED_W-1:0] credits;
    logic last_addr;

    assign last_addr = (addr == ADDR_W'(DEPTH - 1));

    // A credit coming back this cycle may be spent right away
    assign snap_valid_o = (state == SNAP_DRAIN) && ((credits != '0) || snap_credit_i);
    assign snap_data_o  = mem[addr];
    assign snap_busy_o  = (state != SNAP_IDLE);

    // Single address serves capture then drain
    always_ff @(posedge clk_adc) begin
        if (reset_i) begin
            state <= SNAP_IDLE;
            addr  <= '0;
        end else begin
            case (state)
                SNAP_IDLE: begin
                    if (dump_start_i) begin
                        state <= SNAP_CAPTURE;
                        addr  <= '0;
                    end
                end
                SNAP_CAPTURE: begin
                    if (last_addr) begin
                        state <= SNAP_DRAIN;
                        addr  <= '0;
                    end else begin
                        addr <= addr + 1'b1;
                    end
                end
                SNAP_DRAIN: begin
                    // No credit, pointer and data stay put
                    if (snap_valid_o) begin
                        addr <= addr + 1'b1;
                        if (last_addr) begin
                            state <= SNAP_IDLE;
                        end
                    end
                end
                default: begin
                    state <= SNAP_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_adc) begin
        if (state == SNAP_CAPTURE) begin
            mem[addr] <= frame_i;
        end
    end

    always_ff @(posedge clk_adc) begin
        if (reset_i) begin
            credits <= CRED_W'(`DCORE_CREDITS);
        end else begin
            credits <= credits - CRED_W'(snap_valid_o) + CRED_W'(snap_credit_i);
        end
    end

    // Underflow would wrap above the limit
    a_credit_range: assert property (
        @(posedge clk_adc) disable iff (reset_i)
        credits <= CRED_W'(`DCORE_CREDITS)
    );

    a_no_valid_idle: assert property (
        @(posedge clk_adc) disable iff (reset_i)
        (state == SNAP_IDLE) |-> !snap_valid_o
    );

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk_o,
    output logic reset_o
);

    // 4 ns period
    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    initial begin
        reset_o = 1'b1;
        repeat (5) @(posedge clk_o);
        #1 reset_o = 1'b0;
    end

endmodule

// ==== testbench/tb_digital_core.sv ====
`timescale 1ns/1ns

`include "dcore_cfg.svh"

module tb_digital_core;

    import dcore_pkg::*;

    localparam int SW = `DCORE_NADC + 1;
    localparam int NPI = `DCORE_NPI;
    // Scaler, CDR, then four snapshot tests with generous drain time
    localparam int TEST_CYCLES = 60 + 90 + 4 * 260;
    localparam int TIMEOUT_NS = (TEST_CYCLES + 200) * 4;

    logic clk_adc;
    logic reset_i;
    adc_mag_t [`DCORE_NTI-1:0] adc_mag_i;
    logic [`DCORE_NTI-1:0] adc_sign_i;
    logic en_pfd_cal_i;
    logic en_ext_offset_i;
    sample_t [`DCORE_NTI-1:0] ext_offset_i;
    pi_code_t [`DCORE_NOUT-1:0] pi_offset_i;
    pi_code_t [`DCORE_NOUT-1:0] pi_scale_i;
    pi_code_t [`DCORE_NOUT-1:0] pi_ctl_o;
    logic dump_start_i;
    logic snap_credit_i;
    logic snap_valid_o;
    logic snap_busy_o;
    frame_t snap_data_o;

    int seed;
    int errors;
    int test_errors;
    string cur_test;
    frame_t exp_q[$];
    int pend_q[$];
    frame_t rx_exp;
    int cyc;
    int sent_cnt;
    int ret_cnt;
    int rx_cnt;
    logic withhold;
    logic stall_check;

    tb_clock_gen clk_gen (
        .clk_o   (clk_adc),
        .reset_o (reset_i)
    );

    digital_core uut (
        .clk_adc         (clk_adc),
        .reset_i         (reset_i),
        .adc_mag_i       (adc_mag_i),
        .adc_sign_i      (adc_sign_i),
        .en_pfd_cal_i    (en_pfd_cal_i),
        .en_ext_offset_i (en_ext_offset_i),
        .ext_offset_i    (ext_offset_i),
        .pi_offset_i     (pi_offset_i),
        .pi_scale_i      (pi_scale_i),
        .dump_start_i    (dump_start_i),
        .snap_credit_i   (snap_credit_i),
        .pi_ctl_o        (pi_ctl_o),
        .snap_valid_o    (snap_valid_o),
        .snap_data_o     (snap_data_o),
        .snap_busy_o     (snap_busy_o)
    );

    // Signed magnitude minus offset, clamped to the sample range
    function automatic frame_t expect_frame(input adc_mag_t [`DCORE_NTI-1:0] mag,
                                            input logic [`DCORE_NTI-1:0] sgn,
                                            input sample_t [`DCORE_NTI-1:0] off);
        frame_t f;
        int v;
        for (int k = 0; k < `DCORE_NTI; k++) begin
            v = sgn[k] ? int'(mag[k]) : -int'(mag[k]);
            v = v - int'(off[k]);
            if (v > 127) v = 127;
            if (v < -128) v = -128;
            f[k*SW +: SW] = v[SW-1:0];
        end
        return f;
    endfunction

    task automatic step();
        @(posedge clk_adc);
        #1;
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] exp,
                                   input logic [31:0] act);
        errors++;
        $display("MISMATCH %s: %s expected %h actual %h", cur_test, what, exp, act);
    endtask

    task automatic fail_plain(input string msg);
        errors++;
        $display("ERROR in %s: %s", cur_test, msg);
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        $display("Test %s finished with %0d errors", cur_test, errors - test_errors);
    endtask

    task automatic random_inputs();
        for (int k = 0; k < `DCORE_NTI; k++) begin
            adc_mag_i[k] = $random(seed);
        end
        adc_sign_i = $random(seed);
    endtask

    // Drained, all credits home and the buffer back in idle
    task automatic wait_drain();
        while (exp_q.size() != 0 || pend_q.size() != 0 || snap_busy_o) begin
            step();
        end
    endtask

    task automatic dump_const(input frame_t f);
        repeat (`DCORE_DEPTH) exp_q.push_back(f);
        dump_start_i = 1'b1;
        step();
        dump_start_i = 1'b0;
        wait_drain();
    endtask

    task automatic cdr_pattern(input adc_mag_t [`DCORE_NTI-1:0] mags,
                               input logic [`DCORE_NTI-1:0] signs, input bit rising);
        int moves;
        pi_code_t prev;
        pi_code_t want;
        logic ok;
        adc_mag_i = mags;
        adc_sign_i = signs;
        repeat (5) step();
        prev = pi_ctl_o[0];
        moves = 0;
        repeat (30) begin
            step();
            want = rising ? pi_code_t'(prev + 1'b1) : pi_code_t'(prev - 1'b1);
            ok = (pi_ctl_o[0] == prev) || (pi_ctl_o[0] == want);
            // Wrap of the unscaled code
            if (rising && prev >= 509 && pi_ctl_o[0] == 0) ok = 1'b1;
            if (!rising && prev == 0 && pi_ctl_o[0] >= 509) ok = 1'b1;
            assert (ok) else report_mismatch("scaled code step", want, pi_ctl_o[0]);
            if (pi_ctl_o[0] != prev) moves++;
            prev = pi_ctl_o[0];
        end
        assert (moves >= 20) else fail_plain("interpolator code did not follow the pattern");
    endtask

    // Reader model, random credit return delay
    initial begin
        forever begin
            @(posedge clk_adc);
            #1;
            cyc++;
            snap_credit_i = 1'b0;
            if (!withhold && pend_q.size() > 0 && pend_q[0] <= cyc) begin
                void'(pend_q.pop_front());
                snap_credit_i = 1'b1;
                ret_cnt++;
            end
            #1;
            if (snap_valid_o) begin
                sent_cnt++;
                rx_cnt++;
                pend_q.push_back(cyc + 1 + ($unsigned($random(seed)) % 6));
                if (exp_q.size() == 0) begin
                    fail_plain("snapshot word arrived that no dump asked for");
                end else begin
                    rx_exp = exp_q.pop_front();
                    assert (snap_data_o == rx_exp)
                        else report_mismatch("snapshot word", rx_exp, snap_data_o);
                end
            end
        end
    end

    a_credit_flow: assert property (
        @(posedge clk_adc) disable iff (reset_i)
        sent_cnt <= `DCORE_CREDITS + ret_cnt
    ) else fail_plain("drain sent more words than credits allowed");

    a_busy_after_last: assert property (
        @(posedge clk_adc) disable iff (reset_i)
        $fell(snap_busy_o) |-> $past(snap_valid_o)
    ) else fail_plain("busy fell without a final word");

    a_stall_hold: assert property (
        @(posedge clk_adc) stall_check |=> $stable(snap_data_o) && !snap_valid_o
    ) else fail_plain("drain moved while credits were withheld");

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish in %0d ns", TIMEOUT_NS);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        seed = 32'heb50ce47;
        adc_mag_i = '0;
        adc_sign_i = '0;
        en_pfd_cal_i = 1'b0;
        en_ext_offset_i = 1'b0;
        ext_offset_i = '0;
        pi_offset_i = '0;
        pi_scale_i = '0;
        dump_start_i = 1'b0;
        snap_credit_i = 1'b0;
        errors = 0;
        cyc = 0;
        sent_cnt = 0;
        ret_cnt = 0;
        rx_cnt = 0;
        withhold = 1'b0;
        stall_check = 1'b0;
        @(negedge reset_i);
        step();

        // Zero input keeps the code at 0
        start_test("scaler");
        en_ext_offset_i = 1'b1;
        repeat (6) begin
            for (int j = 0; j < `DCORE_NOUT; j++) begin
                pi_offset_i[j] = $random(seed);
                pi_scale_i[j] = $random(seed);
            end
            repeat (4) step();
            for (int j = 0; j < `DCORE_NOUT; j++) begin
                assert (pi_ctl_o[j] == pi_code_t'((int'(pi_offset_i[j]) * int'(pi_scale_i[j]))
                                                  >> NPI))
                    else report_mismatch("pi_ctl_o", (int'(pi_offset_i[j])
                                         * int'(pi_scale_i[j])) >> NPI, pi_ctl_o[j]);
            end
        end
        end_test();

        start_test("cdr_direction");
        pi_offset_i = '0;
        pi_scale_i = {`DCORE_NOUT{pi_code_t'(511)}};
        cdr_pattern({7'd50, 7'd1, 7'd50, 7'd1}, 4'b0011, 1'b1);
        cdr_pattern({7'd1, 7'd50, 7'd1, 7'd50}, 4'b0011, 1'b0);
        end_test();

        start_test("external_offset");
        for (int k = 0; k < `DCORE_NTI; k++) begin
            ext_offset_i[k] = $random(seed);
        end
        random_inputs();
        repeat (3) step();
        dump_const(expect_frame(adc_mag_i, adc_sign_i, ext_offset_i));
        end_test();

        start_test("calibration");
        en_ext_offset_i = 1'b0;
        random_inputs();
        repeat (2) step();
        en_pfd_cal_i = 1'b1;
        repeat (2 * 16 + 4) step();
        en_pfd_cal_i = 1'b0;
        repeat (3) step();
        dump_const('0);
        end_test();

        start_test("credit_flow");
        en_ext_offset_i = 1'b1;
        withhold = 1'b1;
        rx_cnt = 0;
        // First captured word is the input driven just before the request
        for (int i = 0; i < 34; i++) begin
            random_inputs();
            if (i < `DCORE_DEPTH) begin
                exp_q.push_back(expect_frame(adc_mag_i, adc_sign_i, ext_offset_i));
            end
            dump_start_i = (i == 1);
            step();
        end
        repeat (12) step();
        assert (rx_cnt == `DCORE_CREDITS)
            else report_mismatch("words before stall", `DCORE_CREDITS, rx_cnt);
        stall_check = 1'b1;
        repeat (6) step();
        stall_check = 1'b0;
        step();
        withhold = 1'b0;
        wait_drain();
        end_test();

        start_test("dump_while_busy");
        random_inputs();
        repeat (3) step();
        repeat (`DCORE_DEPTH) exp_q.push_back(expect_frame(adc_mag_i, adc_sign_i, ext_offset_i));
        dump_start_i = 1'b1;
        step();
        dump_start_i = 1'b0;
        repeat (10) step();
        dump_start_i = 1'b1;
        step();
        dump_start_i = 1'b0;
        repeat (26) step();
        dump_start_i = 1'b1;
        step();
        dump_start_i = 1'b0;
        wait_drain();
        repeat (10) step();
        assert (!snap_busy_o) else fail_plain("a request while busy started another capture");
        end_test();

        $display("Done: %0d errors, %0d snapshot words received", errors, sent_cnt);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
